//--- src/nes_host_config.svh
// NES host configuration
// Header length, cartridge memory layout, reset hold and multitap bytes

`ifndef NES_HOST_CONFIG_SVH
`define NES_HOST_CONFIG_SVH

// iNES file header
`define NES_HEADER_BYTES 16

// Cartridge memory layout, PRG starts at address zero
`define NES_CHR_BASE 22'h200000

// Page sizes as shifts of the header page counts
`define NES_PRG_PAGE_SHIFT 14
`define NES_CHR_PAGE_SHIFT 13

// Console reset hold after a download, in clock cycles
`define NES_RESET_HOLD 8'd255

// Four-player adapter signature bytes
`define NES_TAP_SIG_P1 8'h08
`define NES_TAP_SIG_P2 8'h04

`endif

//--- src/nes_host_pkg.sv
// NES host types
// Shared vector types and the loader state encoding

package nes_host_pkg;

	// Cartridge memory address, PRG and CHR share one 4 MB space
	typedef logic [21:0] rom_addr_t;

	// File and memory byte
	typedef logic [7:0] rom_byte_t;

	// Mapper flag word handed to the console core
	// [7:0]   mapper number
	// [10:8]  prg size code
	// [13:11] chr size code
	// [14]    mirroring
	// [15]    chr is RAM
	// [16]    four screen
	// [24:17] NES 2.0 submapper byte
	// [25]    has saves
	typedef logic [31:0] mapper_flags_t;

	// Power-of-two size code
	typedef logic [2:0] size_code_t;

	// Controller buttons in host order
	typedef logic [7:0] pad_bits_t;

	typedef enum logic [2:0] {
		S_HEADER, // Collecting the iNES header
		S_PRG, // PRG payload
		S_CHR, // CHR payload
		S_ERROR, // Header rejected
		S_DONE
	} loader_state_t;

endpackage

//--- src/ines_flag_decoder.sv
// iNES flag decoder
// Turns the stored header bytes into the mapper flag word, with NES 2.0
// detection and clean-up of dirty iNES 1.0 headers

`timescale 1ns/1ps

`include "nes_host_config.svh"

module ines_flag_decoder (
	input nes_host_pkg::rom_byte_t header_bytes [`NES_HEADER_BYTES],
	input logic invert_mirroring,
	output nes_host_pkg::mapper_flags_t flags
);

	import nes_host_pkg::*;

	// Smallest code c with pages <= 2^c, saturating at 7
	function automatic size_code_t size_code(input rom_byte_t pages);
		size_code_t code;
		code = 3'd7;
		for (int c = 6; c >= 0; c--) begin
			if (pages <= (8'd1 << c))
				code = size_code_t'(c);
		end
		return code;
	endfunction

	rom_byte_t prg_pages;
	rom_byte_t chr_pages;
	size_code_t prg_size;
	size_code_t chr_size;
	rom_byte_t mapper;
	rom_byte_t submapper;
	logic is_nes20;
	logic is_dirty;
	logic chr_ram;
	logic mirroring;
	logic four_screen;
	logic has_saves;

	assign prg_pages = header_bytes[4]; // 16 KB pages
	assign chr_pages = header_bytes[5]; // 8 KB pages, zero means CHR RAM

	assign prg_size = size_code(prg_pages);
	assign chr_size = size_code(chr_pages);
	assign chr_ram = (chr_pages == 8'd0);

	assign is_nes20 = (header_bytes[7][3:2] == 2'b10);

	// Old tools left junk in the reserved bytes
	assign is_dirty = !is_nes20 && ((header_bytes[9] != 8'd0)
		|| (header_bytes[10] != 8'd0)
		|| (header_bytes[11] != 8'd0)
		|| (header_bytes[12] != 8'd0)
		|| (header_bytes[13] != 8'd0)
		|| (header_bytes[14] != 8'd0)
		|| (header_bytes[15] != 8'd0));

	// Upper nibble from byte 7 only when it can be trusted
	assign mapper = {is_dirty ? 4'h0 : header_bytes[7][7:4], header_bytes[6][7:4]};
	assign submapper = is_nes20 ? header_bytes[8] : 8'h00;

	assign mirroring = header_bytes[6][0] ^ invert_mirroring;
	assign has_saves = header_bytes[6][1]; // Battery backed RAM
	assign four_screen = header_bytes[6][3];

	assign flags = {6'b0, has_saves, submapper, four_screen, chr_ram, mirroring,
		chr_size, prg_size, mapper};

endmodule

//--- src/ines_loader.sv
// iNES loader
// Captures and checks the file header, then steers the PRG and CHR payload
// into cartridge memory as a stream of single-byte writes

`timescale 1ns/1ps

`include "nes_host_config.svh"

module ines_loader (
	input logic clk,
	input logic reset_nes,
	input logic downloading,
	input nes_host_pkg::rom_byte_t file_byte,
	input logic file_wr,
	input logic invert_mirroring,
	output nes_host_pkg::rom_addr_t rom_addr,
	output nes_host_pkg::rom_byte_t rom_data,
	output logic rom_write,
	output logic busy,
	output logic done,
	output logic error,
	output nes_host_pkg::mapper_flags_t flags
);

	import nes_host_pkg::*;

	localparam int HDR_IDX_W = $clog2(`NES_HEADER_BYTES);
	localparam int HDR_CNT_W = HDR_IDX_W + 1;

	loader_state_t state;
	rom_byte_t header_q [`NES_HEADER_BYTES];
	logic [HDR_CNT_W-1:0] hdr_cnt;
	logic [21:0] bytes_left; // Payload bytes still expected in this section
	logic downloading_q;

	logic dl_rise;
	logic hdr_full;
	logic hdr_take;
	logic [HDR_IDX_W-1:0] hdr_slot;
	logic header_ok;
	logic payload_phase;

	assign dl_rise = downloading && !downloading_q;
	assign hdr_full = (hdr_cnt == HDR_CNT_W'(`NES_HEADER_BYTES));

	// A byte arriving with the download edge is header byte 0
	assign hdr_take = file_wr && (dl_rise || (state == S_HEADER && !hdr_full));
	assign hdr_slot = dl_rise ? '0 : hdr_cnt[HDR_IDX_W-1:0];

	// "NES" 0x1A and no trainer
	assign header_ok = (header_q[0] == 8'h4E) && (header_q[1] == 8'h45)
		&& (header_q[2] == 8'h53) && (header_q[3] == 8'h1A) && !header_q[6][2];

	assign payload_phase = (state == S_PRG) || (state == S_CHR);
	assign rom_write = payload_phase && (bytes_left != '0) && file_wr;
	assign rom_data = file_byte;

	always_ff @(posedge clk) begin
		if (hdr_take)
			header_q[hdr_slot] <= file_byte;
	end

	ines_flag_decoder u_flag_decoder (
		.header_bytes (header_q),
		.invert_mirroring (invert_mirroring),
		.flags (flags)
	);

	//////////////////////////////////////////////////
	// Load sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state <= S_HEADER;
			hdr_cnt <= '0;
			bytes_left <= '0;
			rom_addr <= '0;
			busy <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
			downloading_q <= 1'b0;
		end else begin
			downloading_q <= downloading;
			if (dl_rise) begin // New file, start over
				state <= S_HEADER;
				hdr_cnt <= file_wr ? HDR_CNT_W'(1) : '0;
				bytes_left <= '0;
				rom_addr <= '0;
				busy <= 1'b0;
				done <= 1'b0;
				error <= 1'b0;
			end else begin
				case (state)
					S_HEADER: begin
						if (hdr_full) begin
							if (header_ok) begin
								busy <= 1'b1;
								rom_addr <= '0;
								bytes_left <= 22'(header_q[4]) << `NES_PRG_PAGE_SHIFT;
								state <= S_PRG;
							end else begin
								state <= S_ERROR;
							end
						end else if (file_wr) begin
							hdr_cnt <= hdr_cnt + 1'b1;
						end
					end
					S_PRG, S_CHR: begin
						if (bytes_left != '0) begin
							if (file_wr) begin
								bytes_left <= bytes_left - 1'b1;
								rom_addr <= rom_addr + 1'b1;
							end
						end else if (state == S_PRG) begin
							rom_addr <= `NES_CHR_BASE;
							bytes_left <= 22'(header_q[5]) << `NES_CHR_PAGE_SHIFT;
							state <= S_CHR;
						end else begin
							done <= 1'b1;
							busy <= 1'b0;
							state <= S_DONE;
						end
					end
					S_ERROR: begin
						done <= 1'b1;
						error <= 1'b1;
						busy <= 1'b0;
					end
					default: begin
						// S_DONE waits for the next download, trailing bytes dropped
					end
				endcase
			end
		end
	end

endmodule

//--- src/console_reset_ctrl.sv
// Console reset control
// Holds the console in reset until a cartridge is loaded and for a short
// countdown after each download, and latches the mapper flags

`timescale 1ns/1ps

`include "nes_host_config.svh"

module console_reset_ctrl (
	input logic clk,
	input logic reset_nes,
	input logic downloading,
	input logic host_reset,
	input logic loader_busy,
	input logic loader_done,
	input logic loader_error,
	input nes_host_pkg::mapper_flags_t decoded_flags,
	output nes_host_pkg::mapper_flags_t mapper_flags,
	output logic console_reset
);

	import nes_host_pkg::*;

	logic first_dl_seen; // Set once any download has started
	logic [7:0] hold_cnt;
	logic done_q;
	mapper_flags_t flags_q;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			first_dl_seen <= 1'b0;
			hold_cnt <= 8'd0;
			done_q <= 1'b0;
			flags_q <= '0;
		end else begin
			done_q <= loader_done;
			if (downloading)
				first_dl_seen <= 1'b1;

			if (downloading)
				hold_cnt <= `NES_RESET_HOLD;
			else if (!loader_busy && hold_cnt != 8'd0)
				hold_cnt <= hold_cnt - 1'b1;

			if (loader_done && !done_q)
				flags_q <= decoded_flags; // Load finished
			else if (downloading && !loader_done)
				flags_q <= '0;
		end
	end

	assign mapper_flags = downloading ? '0 : flags_q; // Core sees no cartridge mid-load

	assign console_reset = !first_dl_seen || host_reset || loader_error || (hold_cnt != 8'd0);

endmodule

//--- src/joypad_shifter.sv
// Joypad serializer
// Two NES controller ports as 24-bit shift registers that hold the pad and
// then either a multitap pad and signature or all-ones filler

`timescale 1ns/1ps

`include "nes_host_config.svh"

module joypad_shifter (
	input logic clk,
	input logic reset_nes,
	input nes_host_pkg::pad_bits_t joy_a,
	input nes_host_pkg::pad_bits_t joy_b,
	input nes_host_pkg::pad_bits_t joy_c,
	input nes_host_pkg::pad_bits_t joy_d,
	input logic multitap_en,
	input logic joy_swap,
	input logic joypad_strobe,
	input logic [1:0] joypad_clock,
	output logic [1:0] joypad_data
);

	import nes_host_pkg::*;

	localparam pad_bits_t TAP_SIG [2] = '{`NES_TAP_SIG_P1, `NES_TAP_SIG_P2};

	// Host bits into NES serial order with A in bit 0
	function automatic pad_bits_t nes_order(input pad_bits_t pad);
		return {pad[0], pad[1], pad[2], pad[3], pad[7], pad[6], pad[5], pad[4]};
	endfunction

	pad_bits_t main_pad [2];
	pad_bits_t tap_pad [2];
	logic [23:0] load_word [2];
	logic [23:0] shift_q [2];
	logic [1:0] clock_q; // Last clock bit of each port
	logic [1:0] clock_fall;

	assign main_pad[0] = nes_order(joy_swap ? joy_b : joy_a);
	assign main_pad[1] = nes_order(joy_swap ? joy_a : joy_b);
	assign tap_pad[0] = nes_order(joy_c);
	assign tap_pad[1] = nes_order(joy_d);

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			if (multitap_en)
				load_word[i] = {TAP_SIG[i], tap_pad[i], main_pad[i]};
			else
				load_word[i] = {16'hFFFF, main_pad[i]}; // Reads as pressed-all past bit 8
		end
	end

	assign clock_fall = clock_q & ~joypad_clock;

	//////////////////////////////////////////////////
	// Shift registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			shift_q[0] <= '0;
			shift_q[1] <= '0;
			clock_q <= 2'b00;
		end else begin
			clock_q <= joypad_clock;
			for (int i = 0; i < 2; i++) begin
				if (joypad_strobe)
					shift_q[i] <= load_word[i];
				else if (clock_fall[i])
					shift_q[i] <= {1'b0, shift_q[i][23:1]}; // Zero once emptied
			end
		end
	end

	assign joypad_data = {shift_q[1][0], shift_q[0][0]};

endmodule

//--- src/nes_host_top.sv
// NES host front end
// Cartridge loader, console reset control and controller ports

`timescale 1ns/1ps

module nes_host_top (
	input logic clk,
	input logic reset_nes,

	// ROM file stream
	input logic downloading,
	input nes_host_pkg::rom_byte_t file_byte,
	input logic file_wr,
	input logic invert_mirroring,
	input logic host_reset,

	// Host controllers
	input nes_host_pkg::pad_bits_t joy_a,
	input nes_host_pkg::pad_bits_t joy_b,
	input nes_host_pkg::pad_bits_t joy_c,
	input nes_host_pkg::pad_bits_t joy_d,
	input logic multitap_en,
	input logic joy_swap,

	// Console side of the controller ports
	input logic joypad_strobe,
	input logic [1:0] joypad_clock,
	output logic [1:0] joypad_data,

	// Cartridge memory writes
	output nes_host_pkg::rom_addr_t rom_addr,
	output nes_host_pkg::rom_byte_t rom_data,
	output logic rom_write,

	output logic loader_busy,
	output logic loader_done,
	output logic loader_error,
	output nes_host_pkg::mapper_flags_t mapper_flags,
	output logic console_reset
);

	import nes_host_pkg::*;

	mapper_flags_t loader_flags; // Live decode of the header store

	ines_loader u_loader (
		.clk (clk),
		.reset_nes (reset_nes),
		.downloading (downloading),
		.file_byte (file_byte),
		.file_wr (file_wr),
		.invert_mirroring (invert_mirroring),
		.rom_addr (rom_addr),
		.rom_data (rom_data),
		.rom_write (rom_write),
		.busy (loader_busy),
		.done (loader_done),
		.error (loader_error),
		.flags (loader_flags)
	);

	console_reset_ctrl u_reset_ctrl (
		.clk (clk),
		.reset_nes (reset_nes),
		.downloading (downloading),
		.host_reset (host_reset),
		.loader_busy (loader_busy),
		.loader_done (loader_done),
		.loader_error (loader_error),
		.decoded_flags (loader_flags),
		.mapper_flags (mapper_flags),
		.console_reset (console_reset)
	);

	joypad_shifter u_joypad (
		.clk (clk),
		.reset_nes (reset_nes),
		.joy_a (joy_a),
		.joy_b (joy_b),
		.joy_c (joy_c),
		.joy_d (joy_d),
		.multitap_en (multitap_en),
		.joy_swap (joy_swap),
		.joypad_strobe (joypad_strobe),
		.joypad_clock (joypad_clock),
		.joypad_data (joypad_data)
	);

endmodule

//--- test/tb_nes_host_checks.svh
// NES host testbench helpers
// Typed compare tasks, iNES header builder, flag and pad rule models, file stream drivers

task automatic check_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
	if (got !== exp)
		fail_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_byte(input string name, input rom_byte_t got, input rom_byte_t exp);
	if (got !== exp)
		fail_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_flags(input string name, input mapper_flags_t got, input mapper_flags_t exp);
	if (got !== exp)
		fail_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp)
		fail_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
endtask

// Header with magic, page counts, flag bytes 6 to 8 and one reserved byte
task automatic build_header(input rom_byte_t prg, input rom_byte_t chr, input rom_byte_t f6,
		input rom_byte_t f7, input rom_byte_t f8, input rom_byte_t junk);
	hdr = '{default: 8'h00};
	hdr[0] = 8'h4E;
	hdr[1] = 8'h45;
	hdr[2] = 8'h53;
	hdr[3] = 8'h1A;
	hdr[4] = prg;
	hdr[5] = chr;
	hdr[6] = f6;
	hdr[7] = f7;
	hdr[8] = f8;
	hdr[15] = junk;
endtask

function automatic size_code_t size_of(input rom_byte_t pages);
	int c;
	c = 0;
	while (c < 7 && int'(pages) > (1 << c))
		c++;
	return size_code_t'(c);
endfunction

// Flag word of the current header
function automatic mapper_flags_t expected_flags(input logic inv);
	logic nes20;
	logic dirty;
	mapper_flags_t f;
	nes20 = ((hdr[7] & 8'h0C) == 8'h08);
	dirty = 1'b0;
	for (int i = 9; i < `NES_HEADER_BYTES; i++)
		dirty = dirty | (!nes20 && hdr[i] != 8'h00);
	f = '0;
	f[3:0] = hdr[6][7:4];
	f[7:4] = dirty ? 4'h0 : hdr[7][7:4];
	f[10:8] = size_of(hdr[4]);
	f[13:11] = size_of(hdr[5]);
	f[14] = hdr[6][0] ^ inv;
	f[15] = (hdr[5] == 8'h00); // No CHR ROM
	f[16] = hdr[6][3];
	f[24:17] = nes20 ? hdr[8] : 8'h00;
	f[25] = hdr[6][1];
	return f;
endfunction

// Serial bit n comes from host bit src[n], A first and right last
function automatic pad_bits_t serial_order(input pad_bits_t host);
	int src [8] = '{4, 5, 6, 7, 3, 2, 1, 0};
	pad_bits_t s;
	for (int n = 0; n < 8; n++)
		s[n] = host[src[n]];
	return s;
endfunction

task automatic put_byte(input rom_byte_t b, input logic wr_exp, input rom_addr_t addr);
	@(negedge clk);
	file_byte = b;
	file_wr = 1'b1;
	#1;
	check_bit("rom_write", rom_write, wr_exp);
	check_bit("console_reset", console_reset, 1'b1);
	check_flags("mapper_flags", mapper_flags, '0);
	if (wr_exp) begin
		check_addr("rom_addr", rom_addr, addr);
		check_byte("rom_data", rom_data, b);
		check_bit("loader_busy", loader_busy, 1'b1);
	end
endtask

task automatic idle_cycle();
	@(negedge clk);
	file_wr = 1'b0;
	#1;
	check_bit("rom_write", rom_write, 1'b0);
endtask

// Random payload, then one idle cycle for the loader to change section
task automatic send_section(input int count, input rom_addr_t base, input logic wr_exp);
	for (int i = 0; i < count; i++)
		put_byte(rom_byte_t'($random(seed)), wr_exp, base + rom_addr_t'(i));
	idle_cycle();
endtask

//--- test/tb_nes_host_top.sv
// NES host testbench
// Directed loads, header rejection, flag decode, reset hold and joypad ports

`timescale 1ns/1ps

`include "nes_host_config.svh"

module tb_nes_host_top;

	import nes_host_pkg::*;

	// File bytes of all loads, then reset holds, gaps and joypad cycles
	localparam int FILE_BYTES = 24592 + 160 + 16400 + 40976 + 1654800 + 32784 + 16400 + 24592;
	localparam int RUN_CYCLES = FILE_BYTES + 9 * 400 + 1000;
	localparam int WATCHDOG_NS = 2 * RUN_CYCLES * 4;

	logic clk, reset_nes, downloading, file_wr, invert_mirroring, host_reset;
	logic multitap_en, joy_swap, joypad_strobe, console_reset;
	logic rom_write, loader_busy, loader_done, loader_error;
	logic [1:0] joypad_clock, joypad_data;
	rom_byte_t file_byte, rom_data;
	rom_addr_t rom_addr;
	pad_bits_t joy_a, joy_b, joy_c, joy_d;
	mapper_flags_t mapper_flags;
	rom_byte_t hdr [`NES_HEADER_BYTES]; // File under construction
	integer seed;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	`include "tb_nes_host_checks.svh"

	nes_host_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("Watchdog timeout, the tests did not finish in time");
	end

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	// One full download of hdr, then done, flags and reset hold
	task automatic load_file(input logic ok, input logic inv);
		int n;
		invert_mirroring = inv;
		@(negedge clk);
		downloading = 1'b1;
		for (int i = 0; i < `NES_HEADER_BYTES; i++)
			put_byte(hdr[i], 1'b0, '0);
		idle_cycle(); // Header decision
		if (ok) begin
			send_section(int'(hdr[4]) << `NES_PRG_PAGE_SHIFT, '0, 1'b1);
			send_section(int'(hdr[5]) << `NES_CHR_PAGE_SHIFT, `NES_CHR_BASE, 1'b1);
		end else begin
			send_section(64, '0, 1'b0);
		end
		n = 0;
		while (!loader_done) begin
			@(negedge clk);
			#1;
			n++;
			if (n > 20)
				fail_run("loader_done did not rise after the last file byte");
		end
		check_bit("loader_error", loader_error, !ok);
		check_bit("loader_busy", loader_busy, 1'b0);
		@(negedge clk);
		downloading = 1'b0;
		#1;
		n = 0;
		if (ok) begin
			check_flags("mapper_flags", mapper_flags, expected_flags(inv));
			while (console_reset) begin
				@(negedge clk);
				#1;
				n++;
				if (n > 260)
					fail_run("console_reset still high 260 cycles after the download");
			end
			if (n < 255)
				fail_run($sformatf("console_reset fell only %0d cycles after the download", n));
			@(negedge clk);
			host_reset = 1'b1; // Host asks for a console reset
			#1;
			check_bit("console_reset", console_reset, 1'b1);
			@(negedge clk);
			host_reset = 1'b0;
			#1;
			check_bit("console_reset", console_reset, 1'b0);
		end else begin
			repeat (300) begin // Error keeps the console held
				@(negedge clk);
				#1;
				check_bit("console_reset", console_reset, 1'b1);
			end
		end
	endtask

	task automatic test_joypad(input logic tap, input logic swap);
		pad_bits_t pads [4];
		logic [23:0] word [2];
		for (int p = 0; p < 4; p++)
			pads[p] = pad_bits_t'($random(seed));
		@(negedge clk);
		joy_a = pads[0];
		joy_b = pads[1];
		joy_c = pads[2];
		joy_d = pads[3];
		multitap_en = tap;
		joy_swap = swap;
		word[0] = {tap ? `NES_TAP_SIG_P1 : 8'hFF, tap ? serial_order(pads[2]) : 8'hFF,
			serial_order(swap ? pads[1] : pads[0])};
		word[1] = {tap ? `NES_TAP_SIG_P2 : 8'hFF, tap ? serial_order(pads[3]) : 8'hFF,
			serial_order(swap ? pads[0] : pads[1])};
		for (int port = 0; port < 2; port++) begin
			@(negedge clk);
			joypad_strobe = 1'b1;
			@(negedge clk);
			joypad_strobe = 1'b0;
			#1;
			for (int i = 0; i < 24; i++) begin
				check_bit($sformatf("joypad_data[%0d]", port), joypad_data[port], word[port][i]);
				check_bit($sformatf("joypad_data[%0d]", 1 - port), joypad_data[1 - port],
					word[1 - port][0]); // Other port must not shift
				@(negedge clk);
				joypad_clock[port] = 1'b1;
				@(negedge clk);
				joypad_clock[port] = 1'b0;
				@(negedge clk);
				#1;
			end
			check_bit($sformatf("joypad_data[%0d]", port), joypad_data[port], 1'b0);
		end
	endtask

	initial begin
		seed = 32'hcf2e157a;
		reset_nes = 1'b1;
		downloading = 1'b0;
		file_byte = '0;
		file_wr = 1'b0;
		invert_mirroring = 1'b0;
		host_reset = 1'b0;
		joy_a = '0;
		joy_b = '0;
		joy_c = '0;
		joy_d = '0;
		multitap_en = 1'b0;
		joy_swap = 1'b0;
		joypad_strobe = 1'b0;
		joypad_clock = 2'b00;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset_nes = 1'b0;
		#1;
		check_bit("console_reset", console_reset, 1'b1); // No cartridge yet
		check_bit("loader_busy", loader_busy, 1'b0);
		check_bit("loader_done", loader_done, 1'b0);
		check_bit("loader_error", loader_error, 1'b0);
		check_bit("rom_write", rom_write, 1'b0);
		check_flags("mapper_flags", mapper_flags, '0);
		check_bit("joypad_data[0]", joypad_data[0], 1'b0);
		check_bit("joypad_data[1]", joypad_data[1], 1'b0);

		build_header(8'd1, 8'd1, 8'h21, 8'h00, 8'h00, 8'h00);
		load_file(1'b1, 1'b0);

		build_header(8'd1, 8'd1, 8'h00, 8'h00, 8'h00, 8'h00);
		hdr[3] = 8'h1B; // Broken magic
		load_file(1'b0, 1'b0);
		build_header(8'd1, 8'd1, 8'h04, 8'h00, 8'h00, 8'h00); // Trainer present
		load_file(1'b0, 1'b0);

		build_header(8'd1, 8'd0, 8'h12, 8'h30, 8'h00, 8'h00); // CHR RAM with saves
		load_file(1'b1, 1'b0);
		build_header(8'd1, 8'd3, 8'h48, 8'h10, 8'h00, 8'h00);
		load_file(1'b1, 1'b0);
		build_header(8'd1, 8'd200, 8'h01, 8'h40, 8'h00, 8'h00); // Size code saturates
		load_file(1'b1, 1'b0);
		build_header(8'd2, 8'd0, 8'h50, 8'h18, 8'h05, 8'h07); // NES 2.0 with submapper
		load_file(1'b1, 1'b0);
		build_header(8'd1, 8'd0, 8'h40, 8'hA0, 8'h00, 8'h44); // Dirty 1.0 header
		load_file(1'b1, 1'b0);
		build_header(8'd1, 8'd1, 8'h01, 8'h00, 8'h00, 8'h00);
		load_file(1'b1, 1'b1);

		test_joypad(1'b0, 1'b0);
		test_joypad(1'b1, 1'b0);
		test_joypad(1'b0, 1'b1);
		test_joypad(1'b1, 1'b1);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- nes_host_top.f
+incdir+src
+incdir+test
src/nes_host_pkg.sv
src/ines_flag_decoder.sv
src/ines_loader.sv
src/console_reset_ctrl.sv
src/joypad_shifter.sv
src/nes_host_top.sv
test/tb_nes_host_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the NES host testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f nes_host_top.f \
	--top-module tb_nes_host_top \
	-Mdir obj_dir -o tb_nes_host_top

./obj_dir/tb_nes_host_top
